//--- source/sdram_map_settings.svh
// Address map of the sound bank download, included by the RTL and the testbench
`ifndef SDRAM_MAP_SETTINGS_SVH
`define SDRAM_MAP_SETTINGS_SVH

// Game configuration bytes at the start of the ROM stream
`define HEADER_LEN 25'd32

// First byte that lands in the SDRAM bank, right after the header
`define BANK_START 25'h00_0020

// Key PROM region, 256 bytes, never written to SDRAM
`define KEY_START  25'h00_4020

// PCM samples sit this many 16-bit words into the bank
`define PCM_OFFSET 22'h00_1000

`endif

//--- source/sdram_map_pkg.sv
// Shared types for the sound bank memory map, imported by every RTL block
package sdram_map_pkg;

    // Download stream byte address
    typedef logic [24:0] ioctl_addr_t;

    // SDRAM side
    typedef logic [21:0] sdram_addr_t;  // Word address
    typedef logic [15:0] word_t;

    // CPU side
    typedef logic [7:0]  byte_t;
    typedef logic [14:0] snd_addr_t;    // Sound CPU byte address
    typedef logic [16:0] pcm_addr_t;    // Sample fetcher byte address

    // 0 = sound CPU, 1 = PCM
    typedef logic        slot_id_t;

    // Read request sequencing in the arbiter
    typedef enum logic [1:0] {
        IDLE,   // Looking for a miss
        REQ,    // ba_rd up, waiting for ack
        WAIT    // Ack seen, data not stored yet
    } arb_state_t;

endpackage

//--- source/slot_fetch_if.sv
// Grant and return path between the slot arbiter and the result block
`timescale 1ns/1ps

interface slot_fetch_if;
    import sdram_map_pkg::*;

    // Arbiter to result
    logic        valid;     // One pulse per granted miss
    slot_id_t    slot;
    sdram_addr_t tag;

    // Result to arbiter
    logic        rdy;       // Word stored in the slot
    word_t       word;
    logic        hit0;
    logic        hit1;

    modport driver (
        output valid, slot, tag,
        input  rdy, word, hit0, hit1
    );

    modport receiver (
        input  valid, slot, tag,
        output rdy, word, hit0, hit1
    );

endinterface

//--- source/rom_dwnld_decode.sv
// Splits the ROM download into header settings, key PROM strobes and SDRAM word writes
`timescale 1ns/1ps
`include "sdram_map_settings.svh"

module rom_dwnld_decode (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  sdram_map_pkg::ioctl_addr_t ioctl_addr,
    input  sdram_map_pkg::byte_t       ioctl_dout,
    input  logic                       ioctl_wr,
    input  logic                       prog_ack,
    output sdram_map_pkg::sdram_addr_t prog_addr,
    output sdram_map_pkg::word_t       prog_data,
    output logic [1:0]                 prog_mask,   // Active low, bit 0 = low byte
    output logic                       prog_we,
    output logic                       key_we,
    output logic [7:0]                 key_addr,
    output sdram_map_pkg::byte_t       game_id,
    output logic                       dec_en,
    output logic                       dec_type
);
    import sdram_map_pkg::*;

    logic        dl_wr;
    logic        in_header;
    logic        in_key;
    logic        in_bank;
    ioctl_addr_t bank_rel;
    ioctl_addr_t key_rel;
    byte_t       low_byte;  // Even byte waiting for its partner
    logic        low_vld;
    logic        fd_en;

    assign dl_wr     = downloading && ioctl_wr;
    assign in_header = ioctl_addr < `HEADER_LEN;
    assign in_key    = ioctl_addr >= `KEY_START;
    assign in_bank   = (ioctl_addr >= `BANK_START) && !in_key;
    assign bank_rel  = ioctl_addr - `BANK_START;
    assign key_rel   = ioctl_addr - `KEY_START;

    // Header bytes: decoder flags at 0x10, game id at 0x18
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd_en    <= 1'b0;
            dec_type <= 1'b0;
            dec_en   <= 1'b0;
            game_id  <= '0;
        end else begin
            if (dl_wr && in_header) begin
                if (ioctl_addr[4:0] == 5'h10) begin
                    fd_en    <= |ioctl_dout[1:0];
                    dec_type <= ioctl_dout[1];
                end
                if (ioctl_addr[4:0] == 5'h18) begin
                    game_id <= ioctl_dout;
                end
            end
            dec_en <= fd_en;    // Lags the flags by a cycle
        end
    end

    // Key PROM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_we <= 1'b0;
        end else begin
            key_we <= dl_wr && in_key;
        end
    end

    always_ff @(posedge clk) begin
        if (dl_wr && in_key) begin
            key_addr <= key_rel[7:0];
        end
    end

    // Write strobe stays up until the clock after the ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            low_vld <= 1'b0;
        end else begin
            if (dl_wr && in_bank && bank_rel[0]) begin
                prog_we <= 1'b1;
            end else if (prog_ack) begin
                prog_we <= 1'b0;
            end
            if (dl_wr && in_bank) begin
                low_vld <= ~bank_rel[0];
            end
        end
    end

    // Even byte goes low, odd byte completes the word
    always_ff @(posedge clk) begin
        if (dl_wr && in_bank) begin
            if (!bank_rel[0]) begin
                low_byte <= ioctl_dout;
            end else begin
                prog_addr <= bank_rel[22:1];
                prog_data <= {ioctl_dout, low_byte};
                prog_mask <= {1'b0, ~low_vld};  // Skip low half if its byte never came
            end
        end
    end

    // Source must hold off until the SDRAM takes the pending word
    a_no_wr_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we && !prog_ack |-> !ioctl_wr)
        else $error("ioctl_wr while a program write waits for prog_ack");

endmodule

//--- source/slot_arbiter.sv
// Picks which missing read slot goes to SDRAM and runs the rd/ack request
`timescale 1ns/1ps
`include "sdram_map_settings.svh"

module slot_arbiter (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  logic                       snd_cs,
    input  sdram_map_pkg::snd_addr_t   snd_addr,
    input  logic                       pcm_cs,
    input  sdram_map_pkg::pcm_addr_t   pcm_addr,
    input  logic                       ba_ack,
    output sdram_map_pkg::sdram_addr_t ba_addr,
    output logic                       ba_rd,
    slot_fetch_if.driver               fetch
);
    import sdram_map_pkg::*;

    arb_state_t  state;
    sdram_addr_t snd_word;
    sdram_addr_t pcm_word;
    logic        snd_miss;
    logic        pcm_miss;
    logic        grant;
    slot_id_t    grant_slot;

    // Byte address to SDRAM word, PCM shifted into its part of the bank
    assign snd_word = {8'd0, snd_addr[14:1]};
    assign pcm_word = {6'd0, pcm_addr[16:1]} + `PCM_OFFSET;

    // No reads while the bank is being loaded
    assign snd_miss = snd_cs && !fetch.hit0 && !downloading;
    assign pcm_miss = pcm_cs && !fetch.hit1 && !downloading;

    assign grant      = (state == IDLE) && (snd_miss || pcm_miss);
    assign grant_slot = snd_miss ? 1'b0 : 1'b1;     // Sound CPU wins a tie

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            ba_rd       <= 1'b0;
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (grant) begin
                        fetch.valid <= 1'b1;
                        ba_rd       <= 1'b1;
                        state       <= REQ;
                    end
                end
                REQ: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (fetch.rdy) begin
                        state <= IDLE;      // Hit flags are fresh by now
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Granted request, held until the next grant
    always_ff @(posedge clk) begin
        if (grant) begin
            fetch.slot <= grant_slot;
            fetch.tag  <= grant_slot ? pcm_word : snd_word;
        end
    end

    assign ba_addr = fetch.tag;

    a_rd_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
        ba_rd && !ba_ack |=> ba_rd)
        else $error("ba_rd dropped before ba_ack");

    // Completion only for the one fetch in flight, with real data behind it
    a_one_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        fetch.rdy |-> (state == WAIT) && !$isunknown(fetch.word))
        else $error("Fetch completion without an outstanding request");

endmodule

//--- source/slot_result.sv
// Holds the last SDRAM word of each read slot and returns bytes and ok flags
`timescale 1ns/1ps
`include "sdram_map_settings.svh"

module slot_result (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ba_rdy,
    input  sdram_map_pkg::word_t     data_read,
    slot_fetch_if.receiver           fetch,
    input  logic                     snd_cs,
    input  sdram_map_pkg::snd_addr_t snd_addr,
    input  logic                     pcm_cs,
    input  sdram_map_pkg::pcm_addr_t pcm_addr,
    output sdram_map_pkg::byte_t     snd_data,
    output sdram_map_pkg::byte_t     pcm_data,
    output logic                     snd_ok,
    output logic                     pcm_ok
);
    import sdram_map_pkg::*;

    sdram_addr_t tag_q [2];
    word_t       word_q [2];
    logic [1:0]  vld_q;
    logic        pend;          // Fetch granted, data not back yet
    slot_id_t    pend_slot;
    sdram_addr_t pend_tag;
    sdram_addr_t snd_word;
    sdram_addr_t pcm_word;
    logic        fill0;
    logic        fill1;

    assign snd_word = {8'd0, snd_addr[14:1]};
    assign pcm_word = {6'd0, pcm_addr[16:1]} + `PCM_OFFSET;

    assign fetch.hit0 = vld_q[0] && (tag_q[0] == snd_word);
    assign fetch.hit1 = vld_q[1] && (tag_q[1] == pcm_word);

    // Data arriving now for the address a slot is asking for
    assign fill0 = ba_rdy && pend && (pend_slot == 1'b0) && (pend_tag == snd_word);
    assign fill1 = ba_rdy && pend && (pend_slot == 1'b1) && (pend_tag == pcm_word);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend      <= 1'b0;
            vld_q     <= 2'b00;
            fetch.rdy <= 1'b0;
            snd_ok    <= 1'b0;
            pcm_ok    <= 1'b0;
        end else begin
            fetch.rdy <= 1'b0;
            if (fetch.valid) begin
                pend <= 1'b1;
            end
            if (ba_rdy && pend) begin
                pend             <= 1'b0;
                vld_q[pend_slot] <= 1'b1;
                fetch.rdy        <= 1'b1;
            end
            snd_ok <= snd_cs && (fetch.hit0 || fill0);
            pcm_ok <= pcm_cs && (fetch.hit1 || fill1);
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid) begin
            pend_slot <= fetch.slot;
            pend_tag  <= fetch.tag;
        end
        if (ba_rdy && pend) begin
            tag_q[pend_slot]  <= pend_tag;
            word_q[pend_slot] <= data_read;
        end
    end

    assign fetch.word = word_q[pend_slot];

    // Even address in the low half
    assign snd_data = snd_addr[0] ? word_q[0][15:8] : word_q[0][7:0];
    assign pcm_data = pcm_addr[0] ? word_q[1][15:8] : word_q[1][7:0];

    a_rdy_for_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        ba_rdy |-> pend)
        else $error("ba_rdy with no fetch granted");

endmodule

//--- source/sdram_map_top.sv
// Sound bank memory map top, wires the download decoder and both read slots to one SDRAM bank
`timescale 1ns/1ps

module sdram_map_top (
    input  logic                       clk,
    input  logic                       arst_n,

    // ROM download
    input  logic                       downloading,
    input  sdram_map_pkg::ioctl_addr_t ioctl_addr,
    input  sdram_map_pkg::byte_t       ioctl_dout,
    input  logic                       ioctl_wr,
    output sdram_map_pkg::sdram_addr_t prog_addr,
    output sdram_map_pkg::word_t       prog_data,
    output logic [1:0]                 prog_mask,
    output logic                       prog_we,
    input  logic                       prog_ack,

    // Configuration and key PROM
    output logic                       key_we,
    output logic [7:0]                 key_addr,
    output sdram_map_pkg::byte_t       game_id,
    output logic                       dec_en,
    output logic                       dec_type,

    // Sound CPU
    input  logic                       snd_cs,
    input  sdram_map_pkg::snd_addr_t   snd_addr,
    output sdram_map_pkg::byte_t       snd_data,
    output logic                       snd_ok,

    // PCM sample fetcher
    input  logic                       pcm_cs,
    input  sdram_map_pkg::pcm_addr_t   pcm_addr,
    output sdram_map_pkg::byte_t       pcm_data,
    output logic                       pcm_ok,

    // SDRAM bank read
    output sdram_map_pkg::sdram_addr_t ba_addr,
    output logic                       ba_rd,
    input  logic                       ba_ack,
    input  logic                       ba_rdy,
    input  sdram_map_pkg::word_t       data_read
);

    slot_fetch_if fetch ();

    rom_dwnld_decode u_decode (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_ack    ( prog_ack    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .key_we      ( key_we      ),
        .key_addr    ( key_addr    ),
        .game_id     ( game_id     ),
        .dec_en      ( dec_en      ),
        .dec_type    ( dec_type    )
    );

    slot_arbiter u_arbiter (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .snd_cs      ( snd_cs      ),
        .snd_addr    ( snd_addr    ),
        .pcm_cs      ( pcm_cs      ),
        .pcm_addr    ( pcm_addr    ),
        .ba_ack      ( ba_ack      ),
        .ba_addr     ( ba_addr     ),
        .ba_rd       ( ba_rd       ),
        .fetch       ( fetch       )
    );

    slot_result u_result (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .ba_rdy      ( ba_rdy      ),
        .data_read   ( data_read   ),
        .fetch       ( fetch       ),
        .snd_cs      ( snd_cs      ),
        .snd_addr    ( snd_addr    ),
        .pcm_cs      ( pcm_cs      ),
        .pcm_addr    ( pcm_addr    ),
        .snd_data    ( snd_data    ),
        .pcm_data    ( pcm_data    ),
        .snd_ok      ( snd_ok      ),
        .pcm_ok      ( pcm_ok      )
    );

endmodule

//--- tests/sdram_bank_model.sv
// Behavioral SDRAM bank for the testbench, stores program writes and answers reads late
`timescale 1ns/1ps

module sdram_bank_model (
    input  logic                       clk,
    input  sdram_map_pkg::sdram_addr_t prog_addr,
    input  sdram_map_pkg::word_t       prog_data,
    input  logic [1:0]                 prog_mask,
    input  logic                       prog_we,
    output logic                       prog_ack,
    input  sdram_map_pkg::sdram_addr_t ba_addr,
    input  logic                       ba_rd,
    output logic                       ba_ack,
    output logic                       ba_rdy,
    output sdram_map_pkg::word_t       data_read,
    output int                         rd_count,
    output int                         wr_count
);
    import sdram_map_pkg::*;

    word_t       mem [sdram_addr_t];
    logic        take_wr;
    word_t       merged;
    sdram_addr_t rd_word;
    int          gap;

    function automatic word_t word_at(input sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return '0;          // Never written
    endfunction

    function automatic int stored_words();
        return mem.num();
    endfunction

    // Program side, one ack per pending word
    initial begin
        prog_ack = 1'b0;
        wr_count = 0;
        forever begin
            @(posedge clk);
            #1;
            take_wr = prog_we && !prog_ack;
            if (take_wr) begin
                merged = word_at(prog_addr);
                if (!prog_mask[0]) begin
                    merged[7:0] = prog_data[7:0];
                end
                if (!prog_mask[1]) begin
                    merged[15:8] = prog_data[15:8];
                end
                mem[prog_addr] = merged;
                wr_count++;
            end
            #1;
            prog_ack = take_wr;
        end
    end

    // Read side with random ack and data delays
    initial begin
        void'($urandom(45389));
        ba_ack    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        rd_count  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ba_rd) begin
                rd_count++;
                rd_word = ba_addr;
                gap = 1 + ($urandom % 4);
                repeat (gap - 1) @(posedge clk);
                #2 ba_ack = 1'b1;
                @(posedge clk);
                #2 ba_ack = 1'b0;
                gap = 2 + ($urandom % 5);   // 2 to 6 cycles
                repeat (gap - 1) @(posedge clk);
                #2;
                data_read = word_at(rd_word);
                ba_rdy    = 1'b1;
                @(posedge clk);
                #2 ba_rdy = 1'b0;
            end
        end
    end

endmodule

//--- tests/tb_sdram_map.sv
// Testbench for the sound bank map, downloads a computed ROM image and runs a table of slot reads
`timescale 1ns/1ps
`include "sdram_map_settings.svh"

module tb_sdram_map;
    import sdram_map_pkg::*;

    localparam int BANK_BASE    = int'(`BANK_START);
    localparam int KEY_BASE     = int'(`KEY_START);
    localparam int PCM_BYTES    = 2 * int'(`PCM_OFFSET);
    localparam int IMAGE_END    = KEY_BASE + 256;
    localparam int BANK_WORDS   = (KEY_BASE - BANK_BASE) / 2;
    localparam int ACK_TIMEOUT  = 20;
    localparam int READ_TIMEOUT = 60;

    localparam logic [1:0] K_READ = 2'd0;   // Hit or miss, data only
    localparam logic [1:0] K_HIT  = 2'd1;   // Served from the stored word
    localparam logic [1:0] K_PAIR = 2'd2;   // Starts together with the next entry

    typedef struct packed {
        logic [1:0]  kind;
        logic        slot;
        logic [16:0] addr;
        byte_t       exp;
    } read_entry_t;

    logic        clk;
    logic        arst_n;
    logic        downloading;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    logic        ioctl_wr;
    sdram_addr_t prog_addr;
    word_t       prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prog_ack;
    logic        key_we;
    logic [7:0]  key_addr;
    byte_t       game_id;
    logic        dec_en;
    logic        dec_type;
    logic        snd_cs;
    snd_addr_t   snd_addr;
    byte_t       snd_data;
    logic        snd_ok;
    logic        pcm_cs;
    pcm_addr_t   pcm_addr;
    byte_t       pcm_data;
    logic        pcm_ok;
    sdram_addr_t ba_addr;
    logic        ba_rd;
    logic        ba_ack;
    logic        ba_rdy;
    word_t       data_read;
    int          rd_count;
    int          wr_count;
    int          key_seen = 0;
    int          fail_count = 0;
    read_entry_t reads [$];

    sdram_map_top uut (.*);

    sdram_bank_model bank (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            fail_count++;
            stop_run();
        end
    endtask

    // ROM image as the download source sees it
    function automatic byte_t image_byte(input int a);
        int p;
        if (a == 'h10) begin
            return 8'h02;
        end
        if (a == 'h18) begin
            return 8'h37;
        end
        p = a * 3;
        return p[7:0] ^ 8'h5A;
    endfunction

    function automatic byte_t slot_byte(input logic slot, input int addr);
        if (slot) begin
            return image_byte(BANK_BASE + PCM_BYTES + addr);
        end
        return image_byte(BANK_BASE + addr);
    endfunction

    function automatic logic slot_ok(input logic slot);
        return slot ? pcm_ok : snd_ok;
    endfunction

    function automatic byte_t slot_data(input logic slot);
        return slot ? pcm_data : snd_data;
    endfunction

    task automatic add_entry(input logic [1:0] kind, input logic slot, input int addr);
        read_entry_t e;
        e.kind = kind;
        e.slot = slot;
        e.addr = 17'(addr);
        e.exp  = slot_byte(slot, addr);
        reads.push_back(e);
    endtask

    task automatic set_slot(input logic slot, input logic [16:0] addr, input logic cs);
        if (slot) begin
            pcm_cs   = cs;
            pcm_addr = addr;
        end else begin
            snd_cs   = cs;
            snd_addr = addr[14:0];
        end
    endtask

    // One download byte, then hold off while a word waits for its ack
    task automatic send_byte(input int a);
        int   waited;
        logic busy;
        ioctl_addr = ioctl_addr_t'(a);
        ioctl_dout = image_byte(a);
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
        waited   = 0;
        busy     = 1'b1;
        while (busy) begin
            @(posedge clk);
            #1;
            busy = prog_we && !prog_ack;
            waited++;
            if (busy && waited > ACK_TIMEOUT) begin
                $display("Timeout: prog_ack never came for download byte %0h", a);
                stop_run();
            end
        end
        #1;
    endtask

    task automatic run_read(input read_entry_t e, input logic want_hit);
        int    rd_before;
        int    lat;
        logic  ok;
        byte_t got;
        rd_before = rd_count;
        set_slot(e.slot, e.addr, 1'b1);
        lat = 0;
        ok  = 1'b0;
        got = '0;
        while (!ok) begin
            @(posedge clk);
            #1;
            lat++;
            ok  = slot_ok(e.slot);
            got = slot_data(e.slot);
            if (!ok && lat > READ_TIMEOUT) begin
                $display("Timeout: slot %0d read of %0h never got ok", e.slot, e.addr);
                stop_run();
            end
        end
        #1;
        set_slot(e.slot, e.addr, 1'b0);
        check_value(32'(got), 32'(e.exp), $sformatf("slot %0d data at %0h", e.slot, e.addr));
        if (want_hit) begin
            check_value(32'(lat), 32'd1, "edges from cs to ok on a hit");
            check_value(32'(rd_count), 32'(rd_before), "SDRAM reads during a hit");
        end
        @(posedge clk);     // Idle cycle so ok drops
        #2;
    endtask

    task automatic run_pair(input read_entry_t e0, input read_entry_t e1);
        int    rd_before;
        int    lat;
        logic  done0;
        logic  done1;
        byte_t got0;
        byte_t got1;
        rd_before = rd_count;
        set_slot(e0.slot, e0.addr, 1'b1);
        set_slot(e1.slot, e1.addr, 1'b1);
        lat   = 0;
        done0 = 1'b0;
        done1 = 1'b0;
        got0  = '0;
        got1  = '0;
        while (!(done0 && done1)) begin
            @(posedge clk);
            #1;
            lat++;
            if (!done0 && slot_ok(e0.slot)) begin
                done0 = 1'b1;
                got0  = slot_data(e0.slot);
            end
            if (!done1 && slot_ok(e1.slot)) begin
                done1 = 1'b1;
                got1  = slot_data(e1.slot);
            end
            if (!(done0 && done1) && lat > READ_TIMEOUT) begin
                $display("Timeout: simultaneous reads on both slots did not finish");
                stop_run();
            end
        end
        #1;
        set_slot(e0.slot, e0.addr, 1'b0);
        set_slot(e1.slot, e1.addr, 1'b0);
        check_value(32'(got0), 32'(e0.exp), $sformatf("slot %0d data at %0h", e0.slot, e0.addr));
        check_value(32'(got1), 32'(e1.exp), $sformatf("slot %0d data at %0h", e1.slot, e1.addr));
        check_value(32'(rd_count), 32'(rd_before + 2), "SDRAM reads for a double miss");
        @(posedge clk);
        #2;
    endtask

    // Key PROM strobes come in download order
    always @(posedge clk) begin
        #1;
        if (arst_n && key_we) begin
            check_value(32'(key_addr), 32'(key_seen % 256), "key_addr");
            key_seen++;
        end
    end

    initial begin
        int    a;
        int    w;
        int    i;
        word_t exp_word;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        pcm_cs      = 1'b0;
        pcm_addr    = '0;
        repeat (8) @(posedge clk);
        #2 arst_n = 1'b1;
        check_value(32'({prog_we, ba_rd, key_we, dec_en, snd_ok, pcm_ok}), 32'd0,
                    "outputs after reset");
        @(posedge clk);
        #2;

        downloading = 1'b1;
        for (a = 0; a < IMAGE_END; a++) begin
            send_byte(a);
        end
        downloading = 1'b0;
        @(posedge clk);
        #2;

        check_value(32'(game_id), 32'h37, "game_id");
        check_value(32'(dec_type), 32'd1, "dec_type");
        check_value(32'(dec_en), 32'd1, "dec_en");
        check_value(32'(key_seen), 32'd256, "key_we pulses");
        check_value(32'(wr_count), 32'(BANK_WORDS), "program writes");
        check_value(32'(bank.stored_words()), 32'(BANK_WORDS), "SDRAM words stored");
        for (w = 0; w < BANK_WORDS; w++) begin
            exp_word = {image_byte(BANK_BASE + 2 * w + 1), image_byte(BANK_BASE + 2 * w)};
            check_value(32'(bank.word_at(sdram_addr_t'(w))), 32'(exp_word),
                        $sformatf("SDRAM word %0h", w));
        end

        add_entry(K_READ, 1'b0, 'h0000);
        add_entry(K_HIT,  1'b0, 'h0001);
        add_entry(K_HIT,  1'b0, 'h0000);
        add_entry(K_READ, 1'b0, 'h1235);
        add_entry(K_HIT,  1'b0, 'h1234);
        add_entry(K_READ, 1'b1, 'h0000);
        add_entry(K_HIT,  1'b1, 'h0001);
        add_entry(K_READ, 1'b1, 'h1FFE);
        add_entry(K_HIT,  1'b1, 'h1FFF);
        add_entry(K_PAIR, 1'b0, 'h2A10);
        add_entry(K_PAIR, 1'b1, 'h0C43);
        add_entry(K_HIT,  1'b0, 'h2A11);
        add_entry(K_HIT,  1'b1, 'h0C42);
        add_entry(K_READ, 1'b0, 'h3FFF);
        add_entry(K_PAIR, 1'b0, 'h0100);
        add_entry(K_PAIR, 1'b1, 'h0100);
        add_entry(K_HIT,  1'b1, 'h0101);

        i = 0;
        while (i < reads.size()) begin
            case (reads[i].kind)
                K_PAIR: begin
                    run_pair(reads[i], reads[i + 1]);
                    i += 2;
                end
                K_HIT: begin
                    run_read(reads[i], 1'b1);
                    i++;
                end
                default: begin
                    run_read(reads[i], 1'b0);
                    i++;
                end
            endcase
        end

        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+source
source/sdram_map_pkg.sv
source/slot_fetch_if.sv
source/rom_dwnld_decode.sv
source/slot_arbiter.sv
source/slot_result.sv
source/sdram_map_top.sv
tests/sdram_bank_model.sv
tests/tb_sdram_map.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits nonzero on failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_sdram_map \
    -f src.f -o tb_sdram_map
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sdram_map > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
